//--- cdc_link.f
+incdir+rtl
rtl/cdc_link_pkg.sv
rtl/word_framer.sv
rtl/cdc_fifomem.sv
rtl/wptr_full.sv
rtl/rptr_empty.sv
rtl/cdc_syncfifo.sv
rtl/credit_sender.sv
rtl/cdc_link_top.sv
dv/cdc_link_tb.sv

//--- dv/cdc_link_tb.sv
/* readout link testbench
   clocks, reset, stimulus, reference framing, output compare */
`timescale 1ns/1ps
`include "cdc_link_cfg.svh"

module cdc_link_tb
    import cdc_link_pkg::*;
;

    logic     wclk;
    logic     rclk;
    logic     rrst;
    payload_t in_data;
    logic     in_valid;
    logic     in_ready;
    logic     out_credit;
    payload_t out_data;
    seq_t     out_seq;
    logic     out_valid;
    logic     out_perr;

    integer   seed;
    int       error_count;
    int       tx_count;
    int       rx_count;
    payload_t exp_q[$];

    cdc_link_top cdc_link_top_i (
        .wclk       (wclk),
        .rclk       (rclk),
        .rrst       (rrst),
        .in_data    (in_data),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .out_credit (out_credit),
        .out_data   (out_data),
        .out_seq    (out_seq),
        .out_valid  (out_valid),
        .out_perr   (out_perr)
    );

    // unrelated clocks, 10 ns and 14 ns
    always #5 wclk = ~wclk;
    always #7 rclk = ~rclk;

    // ------------------------------------------------------------
    // expected framed word for the n-th word since reset
    function automatic link_word_t expected_frame(input payload_t payload, input int index);
        seq_t seq;
        logic parity;
        seq    = seq_t'(index % 16);
        parity = ^{seq, payload};
        return {parity, seq, payload};
    endfunction

    task automatic fail_run(input string msg);
        error_count++;
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic compare_value(input string what, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("mismatch at %0t ns: %s got %0h expected %0h",
                               $time, what, got, exp));
        end
    endtask

    // ------------------------------------------------------------
    // accepted words, sampled mid-cycle where handshake is stable
    always @(negedge wclk) begin
        if (!rrst && in_valid === 1'b1 && in_ready === 1'b1) begin
            exp_q.push_back(in_data);
            tx_count++;
        end
    end

    // output compare against the queue
    always @(negedge rclk) begin
        link_word_t exp;
        if (out_valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                fail_run("output word appeared with no accepted word outstanding");
            end
            exp = expected_frame(exp_q.pop_front(), rx_count);
            compare_value("payload", out_data, exp[`CDC_DATA_W-1:0]);
            compare_value("sequence", out_seq, exp[`CDC_DATA_W+3:`CDC_DATA_W]);
            // intact word xors to zero
            compare_value("parity error", out_perr, ^exp);
            rx_count++;
        end
    end

    // ------------------------------------------------------------
    task automatic apply_reset();
        int waited;
        waited = 0;
        compare_value("words outstanding before reset", exp_q.size(), 0);
        @(posedge wclk);
        #1;
        rrst     = 1'b1;
        in_valid = 1'b0;
        repeat (5) @(negedge wclk);
        compare_value("in_ready in reset", in_ready, 1'b0);
        compare_value("out_valid in reset", out_valid, 1'b0);
        @(posedge wclk);
        #1;
        rrst     = 1'b0;
        rx_count = 0;
        tx_count = 0;
        // in_ready rises once the framer leaves reset
        @(negedge wclk);
        while (in_ready !== 1'b1) begin
            waited++;
            if (waited > 20) fail_run("timeout waiting for in_ready after reset");
            @(negedge wclk);
        end
        compare_value("out_valid after reset", out_valid, 1'b0);
        // rclk side leaves reset two rclk cycles later
        repeat (4) @(posedge rclk);
    endtask

    task automatic send_word(input payload_t d);
        int waited;
        waited = 0;
        @(posedge wclk);
        #1;
        in_valid = 1'b1;
        in_data  = d;
        @(negedge wclk);
        while (in_ready !== 1'b1) begin
            waited++;
            if (waited > 200) fail_run("timeout waiting for in_ready while sending");
            @(negedge wclk);
        end
        @(posedge wclk);
        #1;
        in_valid = 1'b0;
    endtask

    task automatic set_credit(input logic v);
        @(posedge rclk);
        #1;
        out_credit = v;
    endtask

    // one rclk cycle high per credit
    task automatic grant_credits(input int n);
        repeat (n) begin
            set_credit(1'b1);
            set_credit(1'b0);
        end
    endtask

    task automatic wait_rx(input int n);
        int waited;
        waited = 0;
        while (rx_count < n) begin
            waited++;
            if (waited > 2000) fail_run("timeout waiting for output words");
            @(posedge rclk);
        end
    endtask

    task automatic expect_quiet(input int n, input int cycles);
        repeat (cycles) @(posedge rclk);
        compare_value("words out without credit", rx_count, n);
    endtask

    // ------------------------------------------------------------
    initial begin
        int low;
        wclk        = 1'b0;
        rclk        = 1'b0;
        rrst        = 1'b1;
        in_data     = '0;
        in_valid    = 1'b0;
        out_credit  = 1'b0;
        seed        = 32'h850749d7;
        error_count = 0;
        tx_count    = 0;
        rx_count    = 0;

        // reset state
        apply_reset();

        // order and framing, ample credit, sequence wraps three times
        set_credit(1'b1);
        repeat (50) begin
            repeat ($unsigned($random(seed)) % 4) @(posedge wclk);
            send_word(payload_t'($random(seed)));
        end
        wait_rx(50);
        set_credit(1'b0);

        // credit limit
        apply_reset();
        repeat (6) send_word(payload_t'($random(seed)));
        expect_quiet(0, 30);
        grant_credits(3);
        wait_rx(3);
        expect_quiet(3, 30);
        grant_credits(3);
        wait_rx(6);

        // full back-pressure, offer words until in_ready stays low
        apply_reset();
        low = 0;
        @(posedge wclk);
        #1;
        in_valid = 1'b1;
        in_data  = payload_t'($random(seed));
        repeat (200) begin
            @(negedge wclk);
            if (in_ready === 1'b1) low = 0;
            else low++;
            if (low >= 20) break;
            @(posedge wclk);
            #1;
            if (low == 0) in_data = payload_t'($random(seed));
        end
        @(posedge wclk);
        #1;
        in_valid = 1'b0;
        compare_value("words stored while full", tx_count, 8);
        expect_quiet(0, 10);
        grant_credits(8);
        wait_rx(8);

        // credit saturation with empty FIFO
        apply_reset();
        grant_credits(10);
        repeat (8) send_word(payload_t'($random(seed)));
        wait_rx(`CDC_CREDIT_MAX);
        expect_quiet(`CDC_CREDIT_MAX, 40);
        grant_credits(8 - `CDC_CREDIT_MAX);
        wait_rx(8);
        repeat (10) @(posedge rclk);
        compare_value("words left outstanding", exp_q.size(), 0);

        if (error_count == 0) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            $display("STATUS: FAIL");
            $fatal(1, "errors seen during run");
        end
    end

endmodule

//--- rtl/cdc_fifomem.sv
/* dual-port FIFO storage
   written on wclk, combinational read port */
`timescale 1ns/1ps
`include "cdc_link_cfg.svh"

module cdc_fifomem
    import cdc_link_pkg::*;
(
    input  logic       wclk,
    input  logic       wen,
    input  addr_t      waddr,
    input  addr_t      raddr,
    input  link_word_t wdata,
    output link_word_t rdata
);

    localparam int DEPTH = 1 << `CDC_ASIZE;

    link_word_t mem [0:DEPTH-1];

    // wen arrives already qualified by full
    always_ff @(posedge wclk) begin
        if (wen) begin
            mem[waddr] <= wdata;
        end
    end

    // async read, word at raddr is stable while not empty
    assign rdata = mem[raddr];

endmodule

//--- rtl/cdc_link_cfg.svh
/* link configuration macros
   payload width, FIFO address size, credit limit */
`ifndef CDC_LINK_CFG_SVH
`define CDC_LINK_CFG_SVH

// ------------------------------------------------------------
// sample payload width in bits
`define CDC_DATA_W 16

// FIFO address bits, depth is 2**CDC_ASIZE words
`define CDC_ASIZE 3

// credits the sender can bank before it saturates
`define CDC_CREDIT_MAX 4
// ------------------------------------------------------------

`endif

//--- rtl/cdc_link_pkg.sv
/* link types
   payload, sequence, framed word, FIFO pointer and credit vectors */
`include "cdc_link_cfg.svh"

package cdc_link_pkg;

    // one detector sample
    typedef logic [`CDC_DATA_W-1:0] payload_t;

    // per-word sequence number, wraps modulo 16
    typedef logic [3:0] seq_t;

    // framed word: parity on top, then sequence, then payload
    typedef logic [`CDC_DATA_W+4:0] link_word_t;

    // memory address and pointer with wrap bit
    typedef logic [`CDC_ASIZE-1:0] addr_t;
    typedef logic [`CDC_ASIZE:0] ptr_t;

    // credit count, holds 0 .. CDC_CREDIT_MAX
    typedef logic [$clog2(`CDC_CREDIT_MAX+1)-1:0] credit_t;

endpackage

//--- rtl/cdc_link_top.sv
/* readout link top level
   framer, async FIFO and credit sender */
`timescale 1ns/1ps

module cdc_link_top
    import cdc_link_pkg::*;
(
    input  logic     wclk,
    input  logic     rclk,
    input  logic     rrst,
    input  payload_t in_data,
    input  logic     in_valid,
    output logic     in_ready,
    input  logic     out_credit,
    output payload_t out_data,
    output seq_t     out_seq,
    output logic     out_valid,
    output logic     out_perr
);

    logic       winc;
    logic       wfull;
    link_word_t wdata;
    logic       rd_rst;
    logic       rinc;
    logic       rempty;
    link_word_t rdata;

    // ------------------------------------------------------------
    // wclk side
    word_framer word_framer_i (
        .wclk     (wclk),
        .rrst     (rrst),
        .in_data  (in_data),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .wfull    (wfull),
        .winc     (winc),
        .wdata    (wdata)
    );

    // clock domain crossing
    cdc_syncfifo cdc_syncfifo_i (
        .wclk   (wclk),
        .rclk   (rclk),
        .rrst   (rrst),
        .rd_rst (rd_rst),
        .winc   (winc),
        .wdata  (wdata),
        .wfull  (wfull),
        .rinc   (rinc),
        .rdata  (rdata),
        .rempty (rempty)
    );

    // ------------------------------------------------------------
    // rclk side
    credit_sender credit_sender_i (
        .rclk       (rclk),
        .rrst       (rrst),
        .rd_rst     (rd_rst),
        .out_credit (out_credit),
        .rempty     (rempty),
        .rinc       (rinc),
        .rdata      (rdata),
        .out_data   (out_data),
        .out_seq    (out_seq),
        .out_valid  (out_valid),
        .out_perr   (out_perr)
    );

endmodule

//--- rtl/cdc_syncfifo.sv
/* asynchronous Gray-pointer FIFO
   storage plus write and read pointer blocks */
`timescale 1ns/1ps

module cdc_syncfifo
    import cdc_link_pkg::*;
(
    input  logic       wclk,
    input  logic       rclk,
    input  logic       rrst,
    input  logic       rd_rst,
    input  logic       winc,
    input  link_word_t wdata,
    output logic       wfull,
    input  logic       rinc,
    output link_word_t rdata,
    output logic       rempty
);

    logic  wen;
    addr_t waddr;
    addr_t raddr;
    ptr_t  wptr;
    ptr_t  rptr;

    // storage
    cdc_fifomem cdc_fifomem_i (
        .wclk  (wclk),
        .wen   (wen),
        .waddr (waddr),
        .raddr (raddr),
        .wdata (wdata),
        .rdata (rdata)
    );

    // write side, wclk domain
    wptr_full wptr_full_i (
        .wclk  (wclk),
        .rrst  (rrst),
        .winc  (winc),
        .rptr  (rptr),
        .wen   (wen),
        .waddr (waddr),
        .wptr  (wptr),
        .wfull (wfull)
    );

    // read side, rclk domain
    rptr_empty rptr_empty_i (
        .rclk   (rclk),
        .rd_rst (rd_rst),
        .rinc   (rinc),
        .wptr   (wptr),
        .raddr  (raddr),
        .rptr   (rptr),
        .rempty (rempty)
    );

endmodule

//--- rtl/credit_sender.sv
/* rclk output stage
   reset sync, credit counter, pop control, output register, parity check */
`timescale 1ns/1ps
`include "cdc_link_cfg.svh"

module credit_sender
    import cdc_link_pkg::*;
(
    input  logic       rclk,
    input  logic       rrst,
    output logic       rd_rst,
    input  logic       out_credit,
    input  logic       rempty,
    output logic       rinc,
    input  link_word_t rdata,
    output payload_t   out_data,
    output seq_t       out_seq,
    output logic       out_valid,
    output logic       out_perr
);

    localparam credit_t CREDIT_MAX = credit_t'(`CDC_CREDIT_MAX);

    logic    rst_meta;
    credit_t credits;

    // ------------------------------------------------------------
    // rrst into rclk, two flops
    always_ff @(posedge rclk) begin
        rst_meta <= rrst;
        rd_rst   <= rst_meta;
    end

    // ------------------------------------------------------------
    // pop whenever credit is banked and a word is waiting
    assign rinc = (credits != '0) & ~rempty;

    // one credit in per grant, one out per pop
    always_ff @(posedge rclk) begin
        if (rd_rst) begin
            credits <= '0;
        end else begin
            case ({out_credit, rinc})
                2'b10: if (credits != CREDIT_MAX) credits <= credits + 1'b1;
                2'b01: credits <= credits - 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    // ------------------------------------------------------------
    // output register, valid one cycle after the pop
    always_ff @(posedge rclk) begin
        if (rd_rst) begin
            out_valid <= 1'b0;
            out_perr  <= 1'b0;
        end else begin
            out_valid <= rinc;
            // whole word xors to zero when intact
            out_perr  <= rinc & (^rdata);
        end
    end

    // payload fields, loaded on each pop
    always_ff @(posedge rclk) begin
        if (rinc) begin
            out_data <= rdata[`CDC_DATA_W-1:0];
            out_seq  <= rdata[`CDC_DATA_W+3:`CDC_DATA_W];
        end
    end

    // credit bank never overflows
    a_credit_max: assert property (@(posedge rclk) disable iff (rd_rst)
        credits <= CREDIT_MAX);

endmodule

//--- rtl/rptr_empty.sv
/* read-side pointer logic
   binary/Gray read pointer, write pointer sync, empty flag */
`timescale 1ns/1ps
`include "cdc_link_cfg.svh"

module rptr_empty
    import cdc_link_pkg::*;
(
    input  logic  rclk,
    input  logic  rd_rst,
    input  logic  rinc,
    input  ptr_t  wptr,
    output addr_t raddr,
    output ptr_t  rptr,
    output logic  rempty
);

    ptr_t rbin;
    ptr_t rbin_next;
    ptr_t rgray_next;
    ptr_t rq1_wptr;
    ptr_t rq2_wptr;
    logic rempty_val;

    // ------------------------------------------------------------
    // write pointer into rclk, two flops
    always_ff @(posedge rclk) begin
        if (rd_rst) begin
            rq1_wptr <= '0;
            rq2_wptr <= '0;
        end else begin
            rq1_wptr <= wptr;
            rq2_wptr <= rq1_wptr;
        end
    end

    // ------------------------------------------------------------
    // read pointer, pop only while something is stored
    assign rbin_next  = rbin + ptr_t'(rinc & ~rempty);
    assign rgray_next = (rbin_next >> 1) ^ rbin_next;
    assign raddr      = rbin[`CDC_ASIZE-1:0];

    always_ff @(posedge rclk) begin
        if (rd_rst) begin
            rbin <= '0;
            rptr <= '0;
        end else begin
            rbin <= rbin_next;
            rptr <= rgray_next;
        end
    end

    // empty once next read ptr catches the synced write ptr
    assign rempty_val = (rgray_next == rq2_wptr);

    always_ff @(posedge rclk) begin
        if (rd_rst) begin
            rempty <= 1'b1;
        end else begin
            rempty <= rempty_val;
        end
    end

    // an honored pop always finds a stored word behind the synced write ptr
    a_no_pop_empty: assert property (@(posedge rclk) disable iff (rd_rst)
        (rinc && !rempty) |-> (rptr != rq2_wptr));

endmodule

//--- rtl/word_framer.sv
/* wclk framing stage
   input handshake, sequence counter and parity generation */
`timescale 1ns/1ps

module word_framer
    import cdc_link_pkg::*;
(
    input  logic       wclk,
    input  logic       rrst,
    input  payload_t   in_data,
    input  logic       in_valid,
    output logic       in_ready,
    input  logic       wfull,
    output logic       winc,
    output link_word_t wdata
);

    seq_t seq_q;
    logic run_q;
    logic parity;

    // input stays closed until the first edge after reset
    always_ff @(posedge wclk) begin
        if (rrst) begin
            run_q <= 1'b0;
        end else begin
            run_q <= 1'b1;
        end
    end

    assign in_ready = run_q & ~wfull;
    assign winc     = in_valid & in_ready;

    // even parity over sequence and payload
    assign parity = ^{seq_q, in_data};
    assign wdata  = {parity, seq_q, in_data};

    // one sequence step per accepted word
    always_ff @(posedge wclk) begin
        if (rrst) begin
            seq_q <= '0;
        end else if (winc) begin
            seq_q <= seq_q + 1'b1;
        end
    end

    // every accepted word goes out with known sequence, parity and payload
    a_known_write: assert property (@(posedge wclk) disable iff (rrst)
        winc |-> !$isunknown(wdata));

endmodule

//--- rtl/wptr_full.sv
/* write-side pointer logic
   binary/Gray write pointer, read pointer sync, full flag */
`timescale 1ns/1ps
`include "cdc_link_cfg.svh"

module wptr_full
    import cdc_link_pkg::*;
(
    input  logic  wclk,
    input  logic  rrst,
    input  logic  winc,
    input  ptr_t  rptr,
    output logic  wen,
    output addr_t waddr,
    output ptr_t  wptr,
    output logic  wfull
);

    ptr_t wbin;
    ptr_t wbin_next;
    ptr_t wgray_next;
    ptr_t wq1_rptr;
    ptr_t wq2_rptr;
    logic wfull_val;

    // ------------------------------------------------------------
    // read pointer into wclk, two flops
    always_ff @(posedge wclk) begin
        if (rrst) begin
            wq1_rptr <= '0;
            wq2_rptr <= '0;
        end else begin
            wq1_rptr <= rptr;
            wq2_rptr <= wq1_rptr;
        end
    end

    // ------------------------------------------------------------
    // write pointer, binary for addressing and Gray for crossing
    assign wen        = winc & ~wfull;
    assign wbin_next  = wbin + ptr_t'(wen);
    assign wgray_next = (wbin_next >> 1) ^ wbin_next;
    assign waddr      = wbin[`CDC_ASIZE-1:0];

    always_ff @(posedge wclk) begin
        if (rrst) begin
            wbin <= '0;
            wptr <= '0;
        end else begin
            wbin <= wbin_next;
            wptr <= wgray_next;
        end
    end

    // full when next Gray equals synced read ptr with top two bits flipped
    assign wfull_val = (wgray_next == {~wq2_rptr[`CDC_ASIZE:`CDC_ASIZE-1],
                                       wq2_rptr[`CDC_ASIZE-2:0]});

    always_ff @(posedge wclk) begin
        if (rrst) begin
            wfull <= 1'b0;
        end else begin
            wfull <= wfull_val;
        end
    end

    // Gray code crossing needs single-bit steps
    a_wgray_step: assert property (@(posedge wclk) disable iff (rrst)
        $countones(wptr ^ $past(wptr)) <= 1);

endmodule
